// File: rtl/tcb_lite_pkg.sv
// fixed bus widths shared by every block; memory depth must be a power of two words
package tcb_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    // data word width
    localparam int unsigned DAT_W = 32;
    // one enable per byte lane
    localparam int unsigned BYT_W = DAT_W / 8;
    // byte address width
    localparam int unsigned ADR_W = 12;

    //////////////////////////////////////////////////////////////////////
    // memory geometry
    //////////////////////////////////////////////////////////////////////

    // depth in words
    localparam int unsigned MEM_WORDS = 256;
    // first byte address outside the memory
    localparam int unsigned MEM_BYTES = MEM_WORDS * BYT_W;
    // word index width
    localparam int unsigned IDX_W = $clog2(MEM_WORDS);
    // lowest address bit of the word index
    localparam int unsigned ADR_LSB = $clog2(BYT_W);

    //////////////////////////////////////////////////////////////////////
    // system
    //////////////////////////////////////////////////////////////////////

    // host ports at the top level
    localparam int unsigned IFN_SYS = 2;
    // select width for those ports
    localparam int unsigned SEL_W = 1;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [DAT_W-1:0] dat_t;
    typedef logic [ADR_W-1:0] adr_t;
    typedef logic [BYT_W-1:0] byt_t;
    typedef logic [SEL_W-1:0] sel_t;
    // memory word index
    typedef logic [IDX_W-1:0] idx_t;

endpackage

// File: rtl/tcb_lite_if.sv
// response is always one cycle after the transfer; no lock, size or endianness fields
`timescale 1ns/1ps

interface tcb_lite_if
    import tcb_lite_pkg::*;
(
    // clock
    input logic man,
    // async reset, active low
    input logic rst_n
);

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // request valid from host
    logic vld;
    // device ready
    logic rdy;

    //////////////////////////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////////////////////////

    // write enable, low means read
    logic wen;
    // byte address
    adr_t adr;
    // byte lane enables
    byt_t byt;
    // write data
    dat_t wdt;

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // read data, one cycle after transfer
    dat_t rdt;
    // error flag, same timing as rdt
    logic err;

    // transfer on this edge
    logic trn;
    assign trn = vld & rdy;

    // requester side
    modport host (
        input  man, rst_n,
        output vld, wen, adr, byt, wdt,
        input  rdy, rdt, err,
        input  trn
    );

    // responder side
    modport dev (
        input  man, rst_n,
        input  vld, wen, adr, byt, wdt,
        output rdy, rdt, err,
        input  trn
    );

endinterface

// File: rtl/tcb_lite_mux.sv
// sel comes from outside with no arbitration; device response delay must be one cycle
`timescale 1ns/1ps

module tcb_lite_mux
    import tcb_lite_pkg::*;
#(
    // number of host ports
    parameter  int unsigned IFN = 2,
    // select width
    localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1
)(
    // host port select
    input  logic [IFL-1:0] sel,
    // hosts connect here
    tcb_lite_if.dev        hst [IFN-1:0],
    // responder connects here
    tcb_lite_if.host       dev
);

    //////////////////////////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////////////////////////

    // host valids gathered into one vector
    logic [IFN-1:0] vld;

    // host request fields, indexable by sel
    logic wen [IFN-1:0];
    adr_t adr [IFN-1:0];
    byt_t byt [IFN-1:0];
    dat_t wdt [IFN-1:0];

    // port that owns the response in flight
    logic [IFL-1:0] own;

    //////////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////////

    // interface arrays take only constant indices
    // so copy each host into plain arrays first
    for (genvar i = 0; i < IFN; i++) begin : gen_req
        assign vld[i] = hst[i].vld;
        assign wen[i] = hst[i].wen;
        assign adr[i] = hst[i].adr;
        assign byt[i] = hst[i].byt;
        assign wdt[i] = hst[i].wdt;
    end

    // selected host goes straight through
    assign dev.vld = vld[sel];
    assign dev.wen = wen[sel];
    assign dev.adr = adr[sel];
    assign dev.byt = byt[sel];
    assign dev.wdt = wdt[sel];

    //////////////////////////////////////////////////////////////////////
    // owner register
    //////////////////////////////////////////////////////////////////////

    // remember which port issued the accepted transfer
    always_ff @(posedge dev.man or negedge dev.rst_n) begin
        if (!dev.rst_n) begin
            own <= '0;
        end else if (dev.trn) begin
            own <= sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < IFN; i++) begin : gen_rsp
        // device back-pressure only reaches the selected host
        // every other host stays held off
        assign hst[i].rdy = (sel == IFL'(i)) ? dev.rdy : 1'b0;
        // response steered by owner, zero elsewhere
        assign hst[i].rdt = (own == IFL'(i)) ? dev.rdt : '0;
        assign hst[i].err = (own == IFL'(i)) ? dev.err : 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a pending request must never point past the last port
    // otherwise the device would see an undefined request
    a_sel_range : assert property (
        @(posedge dev.man) disable iff (!dev.rst_n)
        (|vld) |-> (sel < IFN)
    );

endmodule

// File: rtl/tcb_lite_sram.sv
// always ready; byte addresses at or above MEM_BYTES give err and no write
`timescale 1ns/1ps

module tcb_lite_sram
    import tcb_lite_pkg::*;
(
    // bus from the multiplexer
    tcb_lite_if.dev bus
);

    //////////////////////////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////////////////////////

    // word storage, contents undefined after reset
    dat_t mem [MEM_WORDS];

    // word index from address, low byte bits dropped
    idx_t idx;
    // address falls inside the memory
    logic in_rng;
    // lanes written this cycle
    byt_t wr_byt;
    // read accepted this cycle
    logic rd_en;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // never stalls
    assign bus.rdy = 1'b1;

    assign idx    = bus.adr[ADR_LSB +: IDX_W];
    assign in_rng = (bus.adr < adr_t'(MEM_BYTES));

    // out of range writes are dropped
    assign wr_byt = (bus.trn && bus.wen && in_rng) ? bus.byt : '0;
    assign rd_en  = bus.trn && !bus.wen && in_rng;

    //////////////////////////////////////////////////////////////////////
    // memory array
    //////////////////////////////////////////////////////////////////////

    // byte lane merge into the addressed word
    always_ff @(posedge bus.man) begin
        for (int b = 0; b < BYT_W; b++) begin
            if (wr_byt[b]) begin
                mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // read data one cycle after the transfer
    // writes and range errors return zero
    always_ff @(posedge bus.man or negedge bus.rst_n) begin
        if (!bus.rst_n) begin
            bus.rdt <= '0;
        end else if (bus.trn) begin
            bus.rdt <= rd_en ? mem[idx] : '0;
        end
    end

    // error only follows an out of range transfer
    always_ff @(posedge bus.man or negedge bus.rst_n) begin
        if (!bus.rst_n) begin
            bus.err <= 1'b0;
        end else begin
            bus.err <= bus.trn && !in_rng;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // err belongs to the transfer one edge earlier
    // and an errored response never carries data
    a_err_after_trn : assert property (
        @(posedge bus.man) disable iff (!bus.rst_n)
        bus.err |-> $past(bus.trn) && (bus.rdt == '0)
    );

    // host side must drive a clean valid
    a_vld_known : assert property (
        @(posedge bus.man) disable iff (!bus.rst_n)
        !$isunknown(bus.vld)
    );

endmodule

// File: rtl/tcb_mux_sys.sv
// two host ports share one memory; sel picks the port and must stay below IFN_SYS
`timescale 1ns/1ps

module tcb_mux_sys
    import tcb_lite_pkg::*;
(
    // clock and async reset
    input  logic man,
    input  logic rst_n,
    // host port select
    input  sel_t sel,

    // host port 0
    input  logic h0_vld,
    input  logic h0_wen,
    input  adr_t h0_adr,
    input  byt_t h0_byt,
    input  dat_t h0_wdt,
    output logic h0_rdy,
    output dat_t h0_rdt,
    output logic h0_err,

    // host port 1
    input  logic h1_vld,
    input  logic h1_wen,
    input  adr_t h1_adr,
    input  byt_t h1_byt,
    input  dat_t h1_wdt,
    output logic h1_rdy,
    output dat_t h1_rdt,
    output logic h1_err
);

    //////////////////////////////////////////////////////////////////////
    // interfaces
    //////////////////////////////////////////////////////////////////////

    // one per host port
    tcb_lite_if hst_if [IFN_SYS-1:0] (.man(man), .rst_n(rst_n));
    // memory side
    tcb_lite_if dev_if (.man(man), .rst_n(rst_n));

    //////////////////////////////////////////////////////////////////////
    // plain ports onto host interfaces
    //////////////////////////////////////////////////////////////////////

    // port 0 request
    assign hst_if[0].vld = h0_vld;
    assign hst_if[0].wen = h0_wen;
    assign hst_if[0].adr = h0_adr;
    assign hst_if[0].byt = h0_byt;
    assign hst_if[0].wdt = h0_wdt;
    // port 0 response
    assign h0_rdy = hst_if[0].rdy;
    assign h0_rdt = hst_if[0].rdt;
    assign h0_err = hst_if[0].err;

    // port 1 request
    assign hst_if[1].vld = h1_vld;
    assign hst_if[1].wen = h1_wen;
    assign hst_if[1].adr = h1_adr;
    assign hst_if[1].byt = h1_byt;
    assign hst_if[1].wdt = h1_wdt;
    // port 1 response
    assign h1_rdy = hst_if[1].rdy;
    assign h1_rdt = hst_if[1].rdt;
    assign h1_err = hst_if[1].err;

    //////////////////////////////////////////////////////////////////////
    // multiplexer and memory
    //////////////////////////////////////////////////////////////////////

    // select passes through, width already matches
    tcb_lite_mux #(
        .IFN (IFN_SYS)
    ) u_mux (
        .sel (sel),
        .hst (hst_if),
        .dev (dev_if)
    );

    // single cycle memory responder
    tcb_lite_sram u_sram (
        .bus (dev_if)
    );

endmodule

// File: verification/tcb_mux_sys_tb.sv
// directed tests through both host ports; memory is filled over the bus before any read is checked
`timescale 1ns/1ps

module tcb_mux_sys_tb
    import tcb_lite_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////////////////////////

    // clock period in ns
    localparam int CLK_PER = 8;
    // reset length in cycles
    localparam int RST_CYC = 4;
    // cycles a single access may take, with slack
    localparam int ACC_CYC = 3;
    // give up on rdy after this many cycles
    localparam int RDY_WAIT = 16;
    // cycles port 1 is held off
    localparam int HOLD_CYC = 6;
    // back-to-back reads in the interleave test
    localparam int PIPE_N = 12;
    // random accesses
    localparam int RAND_N = 300;
    // fill, byte lanes, directed and random accesses
    localparam int NUM_ACC = MEM_WORDS + 32 + 8 + RAND_N;
    localparam int TEST_CYCLES = NUM_ACC * ACC_CYC + PIPE_N + HOLD_CYC + 20;
    localparam int MARGIN_NS = 200;
    localparam int TIMEOUT_NS = (RST_CYC + TEST_CYCLES) * CLK_PER + MARGIN_NS;
    // LFSR start value
    localparam logic [31:0] SEED = 32'h0249_85a5;

    //////////////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////////////

    logic man;
    logic rst_n;
    sel_t sel;

    logic h0_vld;
    logic h0_wen;
    adr_t h0_adr;
    byt_t h0_byt;
    dat_t h0_wdt;
    logic h0_rdy;
    dat_t h0_rdt;
    logic h0_err;

    logic h1_vld;
    logic h1_wen;
    adr_t h1_adr;
    byt_t h1_byt;
    dat_t h1_wdt;
    logic h1_rdy;
    dat_t h1_rdt;
    logic h1_err;

    // bookkeeping
    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr_state;

    // expected memory contents
    dat_t ref_mem [MEM_WORDS];

    tcb_mux_sys u_dut (
        .man    (man),
        .rst_n  (rst_n),
        .sel    (sel),
        .h0_vld (h0_vld),
        .h0_wen (h0_wen),
        .h0_adr (h0_adr),
        .h0_byt (h0_byt),
        .h0_wdt (h0_wdt),
        .h0_rdy (h0_rdy),
        .h0_rdt (h0_rdt),
        .h0_err (h0_err),
        .h1_vld (h1_vld),
        .h1_wen (h1_wen),
        .h1_adr (h1_adr),
        .h1_byt (h1_byt),
        .h1_wdt (h1_wdt),
        .h1_rdy (h1_rdy),
        .h1_rdt (h1_rdt),
        .h1_err (h1_err)
    );

    // free running clock
    initial begin
        man = 1'b0;
        forever #(CLK_PER / 2) man = ~man;
    end

    // hard stop if the tests stall
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // 32 bit fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[31]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // request onto one port, takes effect after this edge
    task automatic drive_req(input int port, input logic vld, input logic wen,
                             input adr_t adr, input byt_t byt, input dat_t wdt);
        if (port == 0) begin
            h0_vld <= vld;
            h0_wen <= wen;
            h0_adr <= adr;
            h0_byt <= byt;
            h0_wdt <= wdt;
        end else begin
            h1_vld <= vld;
            h1_wen <= wen;
            h1_adr <= adr;
            h1_byt <= byt;
            h1_wdt <= wdt;
        end
    endtask

    function automatic logic port_rdy(input int port);
        return (port == 0) ? h0_rdy : h1_rdy;
    endfunction

    function automatic dat_t port_rdt(input int port);
        return (port == 0) ? h0_rdt : h1_rdt;
    endfunction

    function automatic logic port_err(input int port);
        return (port == 0) ? h0_err : h1_err;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // byte addresses below MEM_WORDS*BYT_W exist
    function automatic logic in_range(input adr_t adr);
        return int'(adr) < int'(MEM_WORDS * BYT_W);
    endfunction

    task automatic model_write(input adr_t adr, input byt_t byt, input dat_t wdt);
        int w;
        w = int'(adr) / int'(BYT_W);
        if (in_range(adr)) begin
            for (int b = 0; b < BYT_W; b++) begin
                if (byt[b]) ref_mem[w][8*b +: 8] = wdt[8*b +: 8];
            end
        end
    endtask

    // out of range reads give zero
    function automatic dat_t model_read(input adr_t adr);
        return in_range(adr) ? ref_mem[int'(adr) / int'(BYT_W)] : '0;
    endfunction

    // distinct word per index
    function automatic dat_t fill_word(input int w);
        logic [7:0] b;
        b = w[7:0];
        return {b, ~b, b ^ 8'h5a, 8'ha5 - b};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////////////////////////

    // one transfer on a port, response sampled mid cycle after it
    task automatic bus_access(input int port, input logic wen, input adr_t adr,
                              input byt_t byt, input dat_t wdt,
                              output dat_t rdt, output logic err, output logic ok);
        int wait_cyc;
        wait_cyc = 0;
        @(posedge man);
        sel <= sel_t'(port);
        drive_req(port, 1'b1, wen, adr, byt, wdt);
        @(negedge man);
        while (!port_rdy(port) && wait_cyc < RDY_WAIT) begin
            @(negedge man);
            wait_cyc++;
        end
        ok = port_rdy(port);
        // transfer edge when ok
        @(posedge man);
        drive_req(port, 1'b0, 1'b0, '0, '0, '0);
        if (!ok) begin
            errors++;
            $display("port %0d: rdy did not rise within %0d cycles", port, RDY_WAIT);
            rdt = '0;
            err = 1'b0;
        end else begin
            @(negedge man);
            rdt = port_rdt(port);
            err = port_err(port);
        end
    endtask

    task automatic do_write(input string name, input int port, input adr_t adr,
                            input byt_t byt, input dat_t wdt);
        dat_t rdt;
        logic err;
        logic ok;
        bus_access(port, 1'b1, adr, byt, wdt, rdt, err, ok);
        if (ok) check({name, " err"}, !in_range(adr), err);
        model_write(adr, byt, wdt);
    endtask

    task automatic do_read(input string name, input int port, input adr_t adr);
        dat_t rdt;
        logic err;
        logic ok;
        bus_access(port, 1'b0, adr, '0, '0, rdt, err, ok);
        if (ok) begin
            check({name, " rdt"}, model_read(adr), rdt);
            check({name, " err"}, !in_range(adr), err);
        end
    endtask

    // reads every cycle, sel toggles, response checked one cycle later
    task automatic pipe_reads(input string name, input int n, input adr_t base);
        adr_t adr_q [$];
        int   port_q [$];
        int   p;
        int   rp;
        adr_t a;
        adr_t ra;
        p = 0;
        for (int i = 0; i <= n; i++) begin
            @(posedge man);
            if (i < n) begin
                p = i % 2;
                a = base + adr_t'(4 * i);
                sel <= sel_t'(p);
                drive_req(p, 1'b1, 1'b0, a, '1, '0);
                drive_req(1 - p, 1'b0, 1'b0, '0, '0, '0);
                adr_q.push_back(a);
                port_q.push_back(p);
            end else begin
                drive_req(0, 1'b0, 1'b0, '0, '0, '0);
                drive_req(1, 1'b0, 1'b0, '0, '0, '0);
            end
            @(negedge man);
            if (i < n && !port_rdy(p)) begin
                errors++;
                $display("port %0d: rdy low on a selected back-to-back read", p);
            end
            // response of the previous request
            if (i > 0) begin
                ra = adr_q.pop_front();
                rp = port_q.pop_front();
                check({name, " issuer rdt"}, model_read(ra), port_rdt(rp));
                check({name, " other rdt"}, '0, port_rdt(1 - rp));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic init_memory();
        for (int w = 0; w < MEM_WORDS; w++) begin
            do_write("init", w % 2, adr_t'(w * BYT_W), '1, fill_word(w));
        end
    endtask

    task automatic test_port0_access();
        do_write("port0 write", 0, 12'h010, '1, 32'hcafe_0001);
        do_read("port0 read", 0, 12'h010);
        do_write("port0 write", 0, 12'h3fc, '1, 32'h8badf00d);
        do_read("port0 read", 0, 12'h3fc);
    endtask

    // every byte enable pattern merged into one word
    task automatic test_port1_byte_enables();
        for (int i = 0; i < 16; i++) begin
            do_write("port1 byte write", 1, 12'h200, byt_t'(i), rand_bits(32));
            do_read("port1 byte read", 1, 12'h200);
        end
    endtask

    task automatic test_held_off();
        adr_t a;
        a = 12'h0c0;
        @(posedge man);
        sel <= sel_t'(0);
        drive_req(0, 1'b0, 1'b0, '0, '0, '0);
        drive_req(1, 1'b1, 1'b1, a, '1, 32'hdead_beef);
        repeat (HOLD_CYC) begin
            @(negedge man);
            check("held off rdy", 1'b0, h1_rdy);
        end
        @(posedge man);
        drive_req(1, 1'b0, 1'b0, '0, '0, '0);
        // word must still hold the old value
        do_read("held off readback", 1, a);
    endtask

    task automatic test_range_error();
        do_write("range write", 0, 12'h404, '1, 32'h1234_5678);
        do_read("range read", 1, 12'hffc);
        // word the dropped write would alias onto
        do_read("range alias", 0, 12'h004);
    endtask

    task automatic test_interleaved();
        pipe_reads("interleave", PIPE_N, 12'h100);
    endtask

    task automatic test_random();
        int   port;
        logic wen;
        adr_t adr;
        for (int i = 0; i < RAND_N; i++) begin
            port = (rand_bits(1) != 0) ? 1 : 0;
            wen = (rand_bits(1) != 0);
            // about one in eight out of range
            if (rand_bits(3) == 0) begin
                adr = adr_t'(32'h400 | rand_bits(10));
            end else begin
                adr = adr_t'(rand_bits(10));
            end
            if (wen) begin
                do_write("random write", port, adr, byt_t'(rand_bits(BYT_W)), rand_bits(32));
            end else begin
                do_read("random read", port, adr);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lfsr_state = SEED;
        rst_n = 1'b0;
        sel = '0;
        h0_vld = 1'b0;
        h0_wen = 1'b0;
        h0_adr = '0;
        h0_byt = '0;
        h0_wdt = '0;
        h1_vld = 1'b0;
        h1_wen = 1'b0;
        h1_adr = '0;
        h1_byt = '0;
        h1_wdt = '0;
        repeat (RST_CYC) @(posedge man);
        rst_n <= 1'b1;

        init_memory();
        test_port0_access();
        test_port1_byte_enables();
        test_held_off();
        test_range_error();
        test_interleaved();
        test_random();

        repeat (2) @(posedge man);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tcb_mux_sys.f
rtl/tcb_lite_pkg.sv
rtl/tcb_lite_if.sv
rtl/tcb_lite_mux.sv
rtl/tcb_lite_sram.sv
rtl/tcb_mux_sys.sv
verification/tcb_mux_sys_tb.sv
